// File: rtl/isp_cfg_pkg.sv
// --------------------------------------
// datapath sizes shared by the white balance RTL
// import into any module that handles pixels or gains
// --------------------------------------

package isp_cfg_pkg;

	// --------------------------------------
	// pixel stream
	// --------------------------------------
	// bits per pixel word
	localparam int PIX_W    = 10;
	// pixels per clock, lane 0 in the low bits
	localparam int LANE_NUM = 4;

	// --------------------------------------
	// gains
	// --------------------------------------
	// unsigned fixed point, 3 integer bits
	localparam int GAIN_W    = 11;
	localparam int GAIN_FRAC = 8;
	// unity gain, 1.0 in gain format
	localparam logic [GAIN_W-1:0] GAIN_ONE = GAIN_W'(1) << GAIN_FRAC;

	// multiplier product, no bits dropped
	localparam int MULT_W   = GAIN_W + PIX_W;
	// register stages inside the multiplier
	localparam int MULT_LAT = 2;
	// multiplier plus output register
	localparam int GAIN_LAT = MULT_LAT + 1;

endpackage

// File: rtl/isp_video_pkg.sv
// --------------------------------------
// video format codes: bayer layout and test image select
// --------------------------------------

package isp_video_pkg;

	// colour arrangement of the top-left 2x2 tile
	// named row 0 first, then row 1
	typedef enum logic [1:0] {
		BAYER_RGGB = 2'd0,
		BAYER_GRBG = 2'd1,
		BAYER_GBRG = 2'd2,
		BAYER_BGGR = 2'd3
	} bayer_pattern_t;

	// test image select width
	localparam int TEST_SEL_W = 3;

	// real sensor image; any other code is a test image
	// which only acts as a bypass condition here
	localparam logic [TEST_SEL_W-1:0] TEST_IMG_OFF = 3'd0;

endpackage

// File: rtl/bayer_color_flags.sv
// --------------------------------------
// per-lane bayer colour flags from row/column parity
// flags are valid in the same cycle as the pixel
// --------------------------------------
`timescale 1ns/10ps

module bayer_color_flags
	import isp_cfg_pkg::*;
	import isp_video_pkg::*;
(
	input  logic                clk,
	input  logic                i_rst_n,
	input  logic                i_fval,
	input  logic                i_lval,
	input  logic                i_mono_sel,
	input  bayer_pattern_t      i_bayer_pattern,
	output logic [LANE_NUM-1:0] o_r_flag,
	output logic [LANE_NUM-1:0] o_g_flag,
	output logic [LANE_NUM-1:0] o_b_flag
);

	// row parity of the current line
	logic row_odd;
	logic lval_q;
	// green sits where row^col equals g_phase
	logic g_phase;
	// row parity that carries red
	logic r_row;
	logic flag_en;

	// row tracking
	// first line of a frame is row 0
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			row_odd <= 1'b0;
			lval_q  <= 1'b0;
		end else begin
			lval_q <= i_lval;
			if (!i_fval) begin
				row_odd <= 1'b0;
			end else if (lval_q && !i_lval) begin
				// end of line, next row
				row_odd <= ~row_odd;
			end
		end
	end

	// pattern decode into green phase and red row
	always_comb begin
		g_phase = 1'b1;
		r_row   = 1'b0;
		case (i_bayer_pattern)
			BAYER_RGGB: begin
				g_phase = 1'b1;
				r_row   = 1'b0;
			end
			BAYER_GRBG: begin
				g_phase = 1'b0;
				r_row   = 1'b0;
			end
			BAYER_GBRG: begin
				g_phase = 1'b0;
				r_row   = 1'b1;
			end
			BAYER_BGGR: begin
				g_phase = 1'b1;
				r_row   = 1'b1;
			end
			default: ;
		endcase
	end

	// no colour in mono mode or between lines
	assign flag_en = i_lval && !i_mono_sel;

	// lane k sits on column parity k, lane count is even
	for (genvar k = 0; k < LANE_NUM; k++) begin : g_lane
		logic col_odd;
		logic is_green;
		logic is_red;

		assign col_odd  = (k % 2) != 0;
		assign is_green = ((row_odd ^ col_odd) == g_phase);
		assign is_red   = !is_green && (row_odd == r_row);

		assign o_r_flag[k] = flag_en && is_red;
		assign o_g_flag[k] = flag_en && is_green;
		// blue is the remaining colour
		assign o_b_flag[k] = flag_en && !is_green && !is_red;
	end

endmodule

// File: rtl/gain_mult_pipe.sv
// --------------------------------------
// unsigned gain x pixel multiplier, two enabled stages
// --------------------------------------
`timescale 1ns/10ps

module gain_mult_pipe
	import isp_cfg_pkg::*;
(
	input  logic              clk,
	input  logic              i_ce,
	input  logic [GAIN_W-1:0] i_a,
	input  logic [PIX_W-1:0]  i_b,
	output logic [MULT_W-1:0] o_p
);

	// input stage, maps onto the DSP A/B registers
	logic [GAIN_W-1:0] a_q;
	logic [PIX_W-1:0]  b_q;

	// --------------------------------------
	// pipeline, advances only on i_ce
	// --------------------------------------
	always_ff @(posedge clk) begin
		if (i_ce) begin
			a_q <= i_a;
			b_q <= i_b;
		end
	end

	// product stage, DSP P register
	// full width product, never truncated
	always_ff @(posedge clk) begin
		if (i_ce) begin
			o_p <= a_q * b_q;
		end
	end

endmodule

// File: rtl/wb_gain.sv
// --------------------------------------
// white balance: per-colour gain, saturation, bypass
// latency 3 cycles in gain mode, 1 cycle in bypass
// --------------------------------------
`timescale 1ns/10ps

module wb_gain
	import isp_cfg_pkg::*;
	import isp_video_pkg::*;
(
	input  logic                      clk,
	input  logic                      i_rst_n,
	input  logic                      i_fval,
	input  logic                      i_lval,
	input  logic [LANE_NUM*PIX_W-1:0] i_pix_data,
	input  logic [LANE_NUM-1:0]       i_r_flag,
	input  logic [LANE_NUM-1:0]       i_g_flag,
	input  logic [LANE_NUM-1:0]       i_b_flag,
	input  logic                      i_mono_sel,
	input  logic [TEST_SEL_W-1:0]     i_test_image_sel,
	input  logic [GAIN_W-1:0]         i_wb_gain_r,
	input  logic [GAIN_W-1:0]         i_wb_gain_g,
	input  logic [GAIN_W-1:0]         i_wb_gain_b,
	output logic                      o_fval,
	output logic                      o_lval,
	output logic [LANE_NUM*PIX_W-1:0] o_pix_data
);

	logic                gain_en;
	logic                mult_ce;
	// gains held for the whole frame
	logic [GAIN_W-1:0]   gain_r_m;
	logic [GAIN_W-1:0]   gain_g_m;
	logic [GAIN_W-1:0]   gain_b_m;
	// sync delay, matches the multiplier depth
	logic [MULT_LAT-1:0] fval_dly;
	logic [MULT_LAT-1:0] lval_dly;
	// sync selected for the output stage
	logic                sel_fval;
	logic                sel_lval;
	logic                pix_vld;

	// --------------------------------------
	// mode and gain sampling
	// --------------------------------------
	// colour sensor with real image only
	assign gain_en = !i_mono_sel && (i_test_image_sel == TEST_IMG_OFF);

	// follow the inputs during frame blanking
	// frozen while fval is high
	always_ff @(posedge clk) begin
		if (!i_fval) begin
			gain_r_m <= i_wb_gain_r;
			gain_g_m <= i_wb_gain_g;
			gain_b_m <= i_wb_gain_b;
		end
	end

	// --------------------------------------
	// sync delay line
	// --------------------------------------
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			fval_dly <= '0;
			lval_dly <= '0;
		end else begin
			fval_dly <= {fval_dly[MULT_LAT-2:0], i_fval};
			lval_dly <= {lval_dly[MULT_LAT-2:0], i_lval};
		end
	end

	// extra enable after lval drops, drains the last beat
	assign mult_ce = gain_en && (i_lval || lval_dly[0]);

	// bypass takes the undelayed sync
	assign sel_fval = gain_en ? fval_dly[MULT_LAT-1] : i_fval;
	assign sel_lval = gain_en ? lval_dly[MULT_LAT-1] : i_lval;
	// lval only counts inside fval
	assign pix_vld  = sel_fval && sel_lval;

	// output sync registers
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			o_fval <= 1'b0;
			o_lval <= 1'b0;
		end else begin
			o_fval <= sel_fval;
			o_lval <= pix_vld;
		end
	end

	// --------------------------------------
	// per-lane datapath
	// --------------------------------------
	for (genvar k = 0; k < LANE_NUM; k++) begin : g_lane
		logic [PIX_W-1:0]  lane_pix;
		logic [GAIN_W-1:0] lane_gain;
		logic [MULT_W-1:0] prod;
		logic              ovf;
		logic [PIX_W-1:0]  scaled;
		logic [PIX_W-1:0]  pix_q;

		assign lane_pix = i_pix_data[k*PIX_W +: PIX_W];

		// colour select, unity when flags are not one-hot
		always_comb begin
			case ({i_r_flag[k], i_g_flag[k], i_b_flag[k]})
				3'b100:  lane_gain = gain_r_m;
				3'b010:  lane_gain = gain_g_m;
				3'b001:  lane_gain = gain_b_m;
				default: lane_gain = GAIN_ONE;
			endcase
		end

		gain_mult_pipe gain_mult_pipe_i (
			.clk  (clk),
			.i_ce (mult_ce),
			.i_a  (lane_gain),
			.i_b  (lane_pix),
			.o_p  (prod)
		);

		// drop fraction bits, clamp on anything above PIX_W
		assign ovf    = |prod[MULT_W-1:PIX_W+GAIN_FRAC];
		assign scaled = ovf ? '1 : prod[PIX_W+GAIN_FRAC-1:GAIN_FRAC];

		// output register, blanked outside the valid region
		always_ff @(posedge clk) begin
			if (!i_rst_n) begin
				pix_q <= '0;
			end else if (!pix_vld) begin
				pix_q <= '0;
			end else if (gain_en) begin
				pix_q <= scaled;
			end else begin
				pix_q <= lane_pix;
			end
		end

		assign o_pix_data[k*PIX_W +: PIX_W] = pix_q;
	end

endmodule

// File: rtl/wb_gain_top.sv
// --------------------------------------
// white balance subsystem: colour flags feeding the gain block
// --------------------------------------
`timescale 1ns/10ps

module wb_gain_top
	import isp_cfg_pkg::*;
	import isp_video_pkg::*;
(
	input  logic                      clk,
	input  logic                      i_rst_n,
	input  logic                      i_fval,
	input  logic                      i_lval,
	input  logic [LANE_NUM*PIX_W-1:0] i_pix_data,
	input  bayer_pattern_t            i_bayer_pattern,
	input  logic                      i_mono_sel,
	input  logic [TEST_SEL_W-1:0]     i_test_image_sel,
	input  logic [GAIN_W-1:0]         i_wb_gain_r,
	input  logic [GAIN_W-1:0]         i_wb_gain_g,
	input  logic [GAIN_W-1:0]         i_wb_gain_b,
	output logic                      o_fval,
	output logic                      o_lval,
	output logic [LANE_NUM*PIX_W-1:0] o_pix_data
);

	// one-hot colour per lane, same cycle as the pixel
	logic [LANE_NUM-1:0] w_r_flag;
	logic [LANE_NUM-1:0] w_g_flag;
	logic [LANE_NUM-1:0] w_b_flag;

	bayer_color_flags bayer_color_flags_i (
		.clk             (clk),
		.i_rst_n         (i_rst_n),
		.i_fval          (i_fval),
		.i_lval          (i_lval),
		.i_mono_sel      (i_mono_sel),
		.i_bayer_pattern (i_bayer_pattern),
		.o_r_flag        (w_r_flag),
		.o_g_flag        (w_g_flag),
		.o_b_flag        (w_b_flag)
	);

	// gain stage, also owns the sync alignment
	wb_gain wb_gain_i (
		.clk              (clk),
		.i_rst_n          (i_rst_n),
		.i_fval           (i_fval),
		.i_lval           (i_lval),
		.i_pix_data       (i_pix_data),
		.i_r_flag         (w_r_flag),
		.i_g_flag         (w_g_flag),
		.i_b_flag         (w_b_flag),
		.i_mono_sel       (i_mono_sel),
		.i_test_image_sel (i_test_image_sel),
		.i_wb_gain_r      (i_wb_gain_r),
		.i_wb_gain_g      (i_wb_gain_g),
		.i_wb_gain_b      (i_wb_gain_b),
		.o_fval           (o_fval),
		.o_lval           (o_lval),
		.o_pix_data       (o_pix_data)
	);

endmodule

// File: bench/wb_gain_props.sv
// --------------------------------------
// output protocol properties bound into wb_gain_top
// --------------------------------------
`timescale 1ns/10ps

module wb_gain_props
	import isp_cfg_pkg::*;
(
	input logic                      clk,
	input logic                      i_rst_n,
	input logic                      o_fval,
	input logic                      o_lval,
	input logic [LANE_NUM*PIX_W-1:0] o_pix_data
);

	// failed property checks for the closing count
	int fail_cnt = 0;

	// line valid only inside a frame
	a_lval_in_fval: assert property (
		@(posedge clk) disable iff (!i_rst_n)
		o_lval |-> o_fval
	) else begin
		$error("o_lval high while o_fval is low");
		fail_cnt++;
	end

	// data blanked between lines
	a_blank_data: assert property (
		@(posedge clk) disable iff (!i_rst_n)
		!o_lval |-> (o_pix_data == '0)
	) else begin
		$error("o_pix_data not zero outside o_lval");
		fail_cnt++;
	end

	// reset clears the output registers
	a_reset_idle: assert property (
		@(posedge clk)
		!i_rst_n |=> (!o_fval && !o_lval && (o_pix_data == '0))
	) else begin
		$error("outputs not idle in the cycle after reset");
		fail_cnt++;
	end

endmodule

bind wb_gain_top wb_gain_props wb_gain_props_i (
	.clk        (clk),
	.i_rst_n    (i_rst_n),
	.o_fval     (o_fval),
	.o_lval     (o_lval),
	.o_pix_data (o_pix_data)
);

// File: bench/wb_gain_tb.sv
// --------------------------------------
// drives random frames into wb_gain_top
// and checks the outputs against a reference model
// --------------------------------------
`timescale 1ns/10ps

module wb_gain_tb
	import isp_cfg_pkg::*;
	import isp_video_pkg::*;
();

	logic                      clk;
	logic                      i_rst_n;
	logic                      i_fval;
	logic                      i_lval;
	logic [LANE_NUM*PIX_W-1:0] i_pix_data;
	bayer_pattern_t            i_bayer_pattern;
	logic                      i_mono_sel;
	logic [TEST_SEL_W-1:0]     i_test_image_sel;
	logic [GAIN_W-1:0]         i_wb_gain_r;
	logic [GAIN_W-1:0]         i_wb_gain_g;
	logic [GAIN_W-1:0]         i_wb_gain_b;
	logic                      o_fval;
	logic                      o_lval;
	logic [LANE_NUM*PIX_W-1:0] o_pix_data;

	// settings applied at the next falling edge
	bayer_pattern_t        cur_pattern;
	logic                  cur_mono;
	logic [TEST_SEL_W-1:0] cur_test_sel;
	logic [GAIN_W-1:0]     cur_gain [3];
	// model copy of the gains held for the frame
	int unsigned           frame_gain [3];
	bit                    bright_frame;
	// expected outputs indexed by cycle mod 16
	logic                      exp_fval [16];
	logic                      exp_lval [16];
	logic [LANE_NUM*PIX_W-1:0] exp_data [16];
	int cyc;
	int sync_errs;
	int data_errs;
	int prop_errs;
	int timeout_errs;
	int wait_cnt;

	wb_gain_top wb_gain_top_i (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// colour at a site with 0 red, 1 green and 2 blue
	// tile codes read row 0 left to right and then row 1
	function automatic int color_of(bayer_pattern_t pat, int row, int col);
		logic [7:0] tile;
		int idx;
		case (pat)
			BAYER_RGGB: tile = {2'd0, 2'd1, 2'd1, 2'd2};
			BAYER_GRBG: tile = {2'd1, 2'd0, 2'd2, 2'd1};
			BAYER_GBRG: tile = {2'd1, 2'd2, 2'd0, 2'd1};
			default:    tile = {2'd2, 2'd1, 2'd1, 2'd0};
		endcase
		idx = (row % 2) * 2 + (col % 2);
		return int'(tile[(3 - idx) * 2 +: 2]);
	endfunction

	function automatic bit gain_mode();
		return !cur_mono && (cur_test_sel == TEST_IMG_OFF);
	endfunction

	// mix of near unity, full range and large gains
	function automatic logic [GAIN_W-1:0] pick_gain();
		case ($urandom % 3)
			0:       return GAIN_W'(192 + $urandom % 129);
			1:       return GAIN_W'($urandom);
			default: return GAIN_W'(1024 + $urandom % 1024);
		endcase
	endfunction

	task automatic check_outputs();
		int s;
		s = cyc % 16;
		assert (o_fval === exp_fval[s]) else begin
			$display("CHECK FAILED o_fval cycle %0d: got %h expected %h",
				cyc, o_fval, exp_fval[s]);
			sync_errs++;
		end
		assert (o_lval === exp_lval[s]) else begin
			$display("CHECK FAILED o_lval cycle %0d: got %h expected %h",
				cyc, o_lval, exp_lval[s]);
			sync_errs++;
		end
		assert (o_pix_data === exp_data[s]) else begin
			$display("CHECK FAILED o_pix_data cycle %0d: got %h expected %h",
				cyc, o_pix_data, exp_data[s]);
			data_errs++;
		end
		// unwritten slots mean blanking
		exp_fval[s] = 1'b0;
		exp_lval[s] = 1'b0;
		exp_data[s] = '0;
	endtask

	// one falling edge beat that checks, models and drives
	task automatic drive_beat(input logic fv, input logic lv, input int row);
		logic [LANE_NUM*PIX_W-1:0] pix;
		logic [LANE_NUM*PIX_W-1:0] exp_pix;
		int unsigned lane_pix;
		int unsigned scaled;
		int slot;
		@(negedge clk);
		check_outputs();
		exp_pix = '0;
		for (int k = 0; k < LANE_NUM; k++) begin
			lane_pix = bright_frame ? 900 + $urandom % 124 : $urandom % (1 << PIX_W);
			pix[k*PIX_W +: PIX_W] = PIX_W'(lane_pix);
			scaled = (lane_pix * frame_gain[color_of(cur_pattern, row, k)]) >> GAIN_FRAC;
			// clamp instead of wrapping
			if (scaled > (1 << PIX_W) - 1) begin
				scaled = (1 << PIX_W) - 1;
			end
			if (fv && lv) begin
				exp_pix[k*PIX_W +: PIX_W] = gain_mode() ? PIX_W'(scaled) : PIX_W'(lane_pix);
			end
		end
		slot = (cyc + (gain_mode() ? GAIN_LAT : 1)) % 16;
		exp_fval[slot] = fv;
		exp_lval[slot] = fv && lv;
		exp_data[slot] = exp_pix;
		// frame gains track the inputs during blanking only
		if (!fv) begin
			for (int c = 0; c < 3; c++) begin
				frame_gain[c] = cur_gain[c];
			end
		end
		i_fval           = fv;
		i_lval           = lv;
		i_pix_data       = pix;
		i_bayer_pattern  = cur_pattern;
		i_mono_sel       = cur_mono;
		i_test_image_sel = cur_test_sel;
		i_wb_gain_r      = cur_gain[0];
		i_wb_gain_g      = cur_gain[1];
		i_wb_gain_b      = cur_gain[2];
		cyc++;
	endtask

	task automatic run_frame();
		int lines;
		bright_frame = ($urandom % 3) == 0;
		lines = 2 + $urandom % 5;
		repeat ($urandom % 3) drive_beat(1'b1, 1'b0, 0);
		for (int ln = 0; ln < lines; ln++) begin
			repeat (3 + $urandom % 10) begin
				// late gain change that waits for the next frame
				if ($urandom % 12 == 0) begin
					cur_gain[$urandom % 3] = pick_gain();
				end
				drive_beat(1'b1, 1'b1, ln);
			end
			repeat (1 + $urandom % 3) drive_beat(1'b1, 1'b0, ln);
		end
	endtask

	task automatic run_blanking(input bit new_setup);
		int sel;
		// let the previous mode drain first
		repeat (4) drive_beat(1'b0, 1'b0, 0);
		if (new_setup) begin
			sel          = $urandom % 5;
			cur_mono     = (sel == 3);
			cur_test_sel = (sel == 4) ? TEST_SEL_W'(1 + $urandom % 7) : TEST_IMG_OFF;
			cur_pattern  = bayer_pattern_t'($urandom % 4);
		end
		for (int c = 0; c < 3; c++) begin
			cur_gain[c] = pick_gain();
		end
		// stray line pulse outside the frame
		if ($urandom % 3 == 0) begin
			repeat (2 + $urandom % 3) drive_beat(1'b0, 1'b1, 0);
		end
		repeat (4 + $urandom % 6) drive_beat(1'b0, 1'b0, 0);
	endtask

	initial begin
		void'($urandom(62));
		i_rst_n = 1'b0;
		i_fval = 1'b0;
		i_lval = 1'b0;
		i_pix_data = '0;
		i_bayer_pattern = BAYER_RGGB;
		i_mono_sel = 1'b0;
		i_test_image_sel = TEST_IMG_OFF;
		i_wb_gain_r = GAIN_ONE;
		i_wb_gain_g = GAIN_ONE;
		i_wb_gain_b = GAIN_ONE;
		cur_pattern = BAYER_RGGB;
		cur_mono = 1'b0;
		cur_test_sel = TEST_IMG_OFF;
		for (int c = 0; c < 3; c++) begin
			cur_gain[c] = GAIN_ONE;
			frame_gain[c] = GAIN_ONE;
		end
		for (int s = 0; s < 16; s++) begin
			exp_fval[s] = 1'b0;
			exp_lval[s] = 1'b0;
			exp_data[s] = '0;
		end
		// outputs idle from the first reset edge on
		repeat (16) begin
			@(negedge clk);
			assert (!o_fval && !o_lval && o_pix_data == '0) else begin
				$display("CHECK FAILED reset outputs: o_fval %h o_lval %h o_pix_data %h",
					o_fval, o_lval, o_pix_data);
				sync_errs++;
			end
		end
		i_rst_n = 1'b1;
		run_blanking(1'b1);
		repeat (40) begin
			run_frame();
			run_blanking($urandom % 2);
		end
		// bounded drain of the output stream
		wait_cnt = 0;
		while ((o_fval || o_lval) && wait_cnt < 20) begin
			drive_beat(1'b0, 1'b0, 0);
			wait_cnt++;
		end
		if (o_fval || o_lval) begin
			$display("timeout: output stream still active after the last frame");
			timeout_errs++;
		end
		prop_errs = wb_gain_top_i.wb_gain_props_i.fail_cnt;
		$display("errors: %0d sync, %0d data, %0d property, %0d timeout over %0d cycles",
			sync_errs, data_errs, prop_errs, timeout_errs, cyc);
		if (sync_errs + data_errs + prop_errs + timeout_errs == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// File: list.f
rtl/isp_cfg_pkg.sv
rtl/isp_video_pkg.sv
rtl/bayer_color_flags.sv
rtl/gain_mult_pipe.sv
rtl/wb_gain.sv
rtl/wb_gain_top.sv
bench/wb_gain_props.sv
bench/wb_gain_tb.sv

// File: Bender.yml
package:
  name: wb_gain

sources:
  # packages first, then leaf modules up to the top level
  - rtl/isp_cfg_pkg.sv
  - rtl/isp_video_pkg.sv
  - rtl/bayer_color_flags.sv
  - rtl/gain_mult_pipe.sv
  - rtl/wb_gain.sv
  - rtl/wb_gain_top.sv
  - target: simulation
    files:
      - bench/wb_gain_props.sv
      - bench/wb_gain_tb.sv
